// ==== src/rx_dma_macros.svh ====
`ifndef RX_DMA_MACROS_SVH
`define RX_DMA_MACROS_SVH

// Widths of the receive DMA datapath

// Memory and stream data word in bits
`define RX_DMA_DATA_WIDTH 64

// Byte address into the packet memory
`define RX_DMA_ADDR_WIDTH 16

// Byte count carried by the receive descriptor
`define RX_DMA_LEN_WIDTH 16

// Sideband fields copied from the stream into the descriptor
`define RX_DMA_DEST_WIDTH 8
`define RX_DMA_USER_WIDTH 2

// One strobe bit per data byte
`define RX_DMA_STRB_WIDTH (`RX_DMA_DATA_WIDTH / 8)

// Address bits that select a byte inside one word
`define RX_DMA_MASK_BITS $clog2(`RX_DMA_STRB_WIDTH)

`endif

// ==== src/rx_dma_pkg.sv ====
`include "rx_dma_macros.svh"

package rx_dma_pkg;

  // Scalar types shared by all stages
  typedef logic [`RX_DMA_DATA_WIDTH-1:0] data_t;
  typedef logic [`RX_DMA_STRB_WIDTH-1:0] strb_t;
  typedef logic [`RX_DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`RX_DMA_LEN_WIDTH-1:0]  len_t;
  typedef logic [`RX_DMA_DEST_WIDTH-1:0] dest_t;
  typedef logic [`RX_DMA_USER_WIDTH-1:0] user_t;

  // Shift needs one bit more than the byte offset, an aligned base gives a full word
  typedef logic [`RX_DMA_MASK_BITS:0] shift_t;

  // Write side packet tracking
  typedef enum logic {
    WR_IDLE = 1'b0,
    WR_PROC = 1'b1
  } wr_state_e;

  // One beat as it arrives on the stream input
  typedef struct packed {
    data_t data;
    strb_t keep;
    logic  last;
    dest_t dest;
    user_t user;
  } axis_beat_t;

  // Per packet values latched on the first beat
  typedef struct packed {
    addr_t  start_addr;
    shift_t shift;
    dest_t  dest;
    user_t  user;
  } pkt_meta_t;

  // Stage one contents handed to the realign and descriptor stages
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  en;
    logic  first;
    logic  last_pkt;
  } stage_word_t;

  // Word aligned memory write request
  typedef struct packed {
    logic  en;
    strb_t strb;
    addr_t addr;
    data_t data;
    logic  last;
  } mem_wr_t;

  // Receive descriptor issued after the final write of a packet
  typedef struct packed {
    addr_t addr;
    len_t  len;
    dest_t dest;
    user_t user;
  } recv_desc_t;

endpackage

// ==== src/rx_ingress.sv ====
`timescale 1ns/1ps
`include "rx_dma_macros.svh"

module rx_ingress (
  input  logic                    clk,
  input  logic                    rst,
  input  rx_dma_pkg::axis_beat_t  s_axis,
  input  logic                    s_axis_valid,
  output logic                    s_axis_ready,
  input  rx_dma_pkg::addr_t       wr_base_addr,
  input  logic                    mem_wr_ready,
  input  logic                    desc_stall,
  output rx_dma_pkg::pkt_meta_t   meta,
  output rx_dma_pkg::stage_word_t word
);
  import rx_dma_pkg::*;

  wr_state_e state_r;
  wr_state_e state_n;

  // Handshake and pipeline movement
  logic      accept;
  logic      advance;
  logic      latch_info;
  logic      extra_cycle;
  logic      last_pkt;

  // Stage one registers
  data_t     data_1;
  strb_t     strb_1;
  logic      last_r;
  logic      word_en;
  logic      first_r;
  logic      strb_left;
  logic      extra_cycle_r;

  pkt_meta_t meta_r;
  shift_t    new_shift;

  ////////////////////////////////////////
  // Packet tracking
  ////////////////////////////////////////

  assign accept  = s_axis_valid && s_axis_ready;
  assign advance = word_en && mem_wr_ready;

  // Bytes shifted past the word end mean the tail needs its own write
  assign extra_cycle = last_r && strb_left;

  // The final write is either the last beat itself or the extra tail write after it
  assign last_pkt = word_en && ((last_r && !extra_cycle) || extra_cycle_r);

  // A packet starts from idle or right as the previous one leaves
  assign latch_info = ((state_r == WR_IDLE) || (last_pkt && mem_wr_ready)) && accept;

  always_comb begin
    state_n = state_r;
    case (state_r)
      WR_IDLE: begin
        if (accept) begin
          state_n = WR_PROC;
        end
      end
      WR_PROC: begin
        // Stay busy when the next packet starts in the same cycle
        if (last_pkt && mem_wr_ready && !accept) begin
          state_n = WR_IDLE;
        end
      end
      default: state_n = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r <= WR_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  ////////////////////////////////////////
  // Metadata latch
  ////////////////////////////////////////

  // Right shift that moves packet byte zero to its byte lane in memory
  assign new_shift = shift_t'(`RX_DMA_STRB_WIDTH)
                     - shift_t'(wr_base_addr[`RX_DMA_MASK_BITS-1:0]);

  always_ff @(posedge clk) begin
    if (latch_info) begin
      meta_r.start_addr <= wr_base_addr;
      meta_r.shift      <= new_shift;
      meta_r.dest       <= s_axis.dest;
      meta_r.user       <= s_axis.user;
    end
  end

  // Leftover bytes are worked out one beat early to keep the ready path short
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_left <= 1'b0;
    end else if (extra_cycle && advance) begin
      strb_left <= 1'b0;
    end else if (latch_info) begin
      strb_left <= |(s_axis.keep >> new_shift);
    end else if (accept) begin
      strb_left <= |(s_axis.keep >> meta_r.shift);
    end
  end

  ////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      data_1 <= s_axis.data;
    end
  end

  // Once the last word moves on, an empty stage one lets the tail drain from stage two
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_1 <= '0;
      last_r <= 1'b0;
    end else if (extra_cycle && advance) begin
      strb_1 <= '0;
      last_r <= 1'b0;
    end else if (accept) begin
      strb_1 <= s_axis.keep;
      last_r <= s_axis.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      word_en       <= 1'b0;
      first_r       <= 1'b0;
      extra_cycle_r <= 1'b0;
    end else begin
      // Enable holds under back-pressure and repeats once for a tail write
      word_en <= accept || (advance && extra_cycle) || (word_en && !mem_wr_ready);
      first_r <= latch_info || (first_r && !mem_wr_ready);
      if (advance) begin
        extra_cycle_r <= extra_cycle;
      end
    end
  end

  // No input during a tail write, and last beats wait for a free descriptor slot
  assign s_axis_ready = mem_wr_ready && !extra_cycle && !(s_axis.last && desc_stall);

  assign meta          = meta_r;
  assign word.data     = data_1;
  assign word.strb     = strb_1;
  assign word.en       = word_en;
  assign word.first    = first_r;
  assign word.last_pkt = last_pkt;

  // The tail write only follows cycles in which the stream input was held off
  a_extra_no_input: assert property (@(posedge clk) disable iff (rst)
    (extra_cycle_r && word_en) |-> $past(!s_axis_ready));

endmodule

// ==== src/rx_realign.sv ====
`timescale 1ns/1ps
`include "rx_dma_macros.svh"

module rx_realign (
  input  logic                    clk,
  input  logic                    rst,
  input  rx_dma_pkg::pkt_meta_t   meta,
  input  rx_dma_pkg::stage_word_t word,
  input  logic                    mem_wr_ready,
  output rx_dma_pkg::mem_wr_t     mem_wr
);
  import rx_dma_pkg::*;

  // Stage two holds the word written just before
  data_t data_2;
  strb_t strb_2;

  logic  advance;
  addr_t next_addr;
  addr_t aligned_addr;
  addr_t wr_addr;

  // Both stages side by side, shifted down to the memory word
  logic [2*`RX_DMA_DATA_WIDTH-1:0] data_cat;
  logic [2*`RX_DMA_STRB_WIDTH-1:0] strb_cat;

  assign advance = word.en && mem_wr_ready;

  ////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      data_2 <= word.data;
    end
  end

  // An empty stage two means the next packet's first write carries only its own bytes
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_2 <= '0;
    end else if (word.last_pkt && mem_wr_ready) begin
      strb_2 <= '0;
    end else if (advance) begin
      strb_2 <= word.strb;
    end
  end

  ////////////////////////////////////////
  // Byte realignment
  ////////////////////////////////////////

  // Stage one sits in the upper half, so older bytes end up in the low lanes
  assign data_cat = {word.data, data_2} >> {meta.shift, 3'b000};
  assign strb_cat = {word.strb, strb_2} >> meta.shift;

  ////////////////////////////////////////
  // Write address
  ////////////////////////////////////////

  // First write goes to the word that holds the start byte
  assign aligned_addr = {meta.start_addr[`RX_DMA_ADDR_WIDTH-1:`RX_DMA_MASK_BITS],
                         {`RX_DMA_MASK_BITS{1'b0}}};

  assign wr_addr = word.first ? aligned_addr : next_addr;

  // Each accepted write moves on by one word
  always_ff @(posedge clk) begin
    if (advance) begin
      next_addr <= wr_addr + addr_t'(`RX_DMA_STRB_WIDTH);
    end
  end

  assign mem_wr.en   = word.en;
  assign mem_wr.strb = strb_cat[`RX_DMA_STRB_WIDTH-1:0];
  assign mem_wr.addr = wr_addr;
  assign mem_wr.data = data_cat[`RX_DMA_DATA_WIDTH-1:0];
  assign mem_wr.last = word.last_pkt;

  // Memory writes are whole words, the byte placement is all in the strobe
  a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_wr.en |-> (mem_wr.addr[`RX_DMA_MASK_BITS-1:0] == '0));

endmodule

// ==== src/rx_desc_gen.sv ====
`timescale 1ns/1ps
`include "rx_dma_macros.svh"

module rx_desc_gen (
  input  logic                   clk,
  input  logic                   rst,
  input  rx_dma_pkg::pkt_meta_t  meta,
  input  rx_dma_pkg::mem_wr_t    mem_wr,
  input  logic                   mem_wr_ready,
  output rx_dma_pkg::recv_desc_t recv_desc,
  output logic                   recv_desc_valid,
  input  logic                   recv_desc_ready,
  output logic                   desc_stall
);
  import rx_dma_pkg::*;

  logic [`RX_DMA_MASK_BITS:0] one_count;
  len_t       pkt_len;
  len_t       next_len;
  logic       wr_done;
  logic       last_done;
  recv_desc_t desc_r;
  logic       desc_v_r;

  assign wr_done   = mem_wr.en && mem_wr_ready;
  assign last_done = wr_done && mem_wr.last;

  ////////////////////////////////////////
  // Length accumulation
  ////////////////////////////////////////

  // Bytes carried by the current write
  always_comb begin
    one_count = '0;
    for (int i = 0; i < `RX_DMA_STRB_WIDTH; i++) begin
      one_count = one_count + {{`RX_DMA_MASK_BITS{1'b0}}, mem_wr.strb[i]};
    end
  end

  assign next_len = pkt_len + len_t'(one_count);

  // Clearing after the last write restarts the count on the next first word
  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_len <= '0;
    end else if (last_done) begin
      pkt_len <= '0;
    end else if (wr_done) begin
      pkt_len <= next_len;
    end
  end

  ////////////////////////////////////////
  // Descriptor register
  ////////////////////////////////////////

  // Meta still belongs to this packet, a new one only latches at the clock edge
  always_ff @(posedge clk) begin
    if (last_done) begin
      desc_r.addr <= meta.start_addr;
      desc_r.len  <= next_len;
      desc_r.dest <= meta.dest;
      desc_r.user <= meta.user;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_v_r <= 1'b0;
    end else if (last_done) begin
      desc_v_r <= 1'b1;
    end else if (recv_desc_ready) begin
      desc_v_r <= 1'b0;
    end
  end

  // A final write in flight also counts, its descriptor lands on the next clock
  assign desc_stall = (desc_v_r && !recv_desc_ready) || (mem_wr.en && mem_wr.last);

  assign recv_desc       = desc_r;
  assign recv_desc_valid = desc_v_r;

  // Holding off last beats upstream keeps a waiting descriptor from being overwritten
  a_desc_stable: assert property (@(posedge clk) disable iff (rst)
    (recv_desc_valid && !recv_desc_ready) |=> (recv_desc_valid && $stable(recv_desc)));

endmodule

// ==== src/rx_dma_top.sv ====
`timescale 1ns/1ps

module rx_dma_top (
  input  logic                   clk,
  input  logic                   rst,

  // Stream input
  input  rx_dma_pkg::axis_beat_t s_axis,
  input  logic                   s_axis_valid,
  output logic                   s_axis_ready,
  input  rx_dma_pkg::addr_t      wr_base_addr,

  // Memory write port
  output rx_dma_pkg::mem_wr_t    mem_wr,
  input  logic                   mem_wr_ready,

  // Receive descriptor
  output rx_dma_pkg::recv_desc_t recv_desc,
  output logic                   recv_desc_valid,
  input  logic                   recv_desc_ready
);
  import rx_dma_pkg::*;

  // Stage one outputs shared by realign and descriptor logic
  pkt_meta_t   meta;
  stage_word_t word;
  logic        desc_stall;

  rx_ingress rx_ingress_i (
    .clk          (clk),
    .rst          (rst),
    .s_axis       (s_axis),
    .s_axis_valid (s_axis_valid),
    .s_axis_ready (s_axis_ready),
    .wr_base_addr (wr_base_addr),
    .mem_wr_ready (mem_wr_ready),
    .desc_stall   (desc_stall),
    .meta         (meta),
    .word         (word)
  );

  rx_realign rx_realign_i (
    .clk          (clk),
    .rst          (rst),
    .meta         (meta),
    .word         (word),
    .mem_wr_ready (mem_wr_ready),
    .mem_wr       (mem_wr)
  );

  // Sees the same write request as the memory
  rx_desc_gen rx_desc_gen_i (
    .clk             (clk),
    .rst             (rst),
    .meta            (meta),
    .mem_wr          (mem_wr),
    .mem_wr_ready    (mem_wr_ready),
    .recv_desc       (recv_desc),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready),
    .desc_stall      (desc_stall)
  );

endmodule

// ==== testbench/rx_dma_tb.sv ====
`timescale 1ns/1ps

module rx_dma_tb;
  import rx_dma_pkg::*;

  // One row per packet with the memory and descriptor side behavior for that packet
  typedef struct packed {
    addr_t      base;
    len_t       len;
    dest_t      dest;
    user_t      user;
    logic       bp;
    logic [3:0] delay;
  } pkt_row_t;

  logic       clk;
  logic       rst;
  axis_beat_t s_axis;
  logic       s_axis_valid;
  logic       s_axis_ready;
  addr_t      wr_base_addr;
  mem_wr_t    mem_wr;
  logic       mem_wr_ready;
  recv_desc_t recv_desc;
  logic       recv_desc_valid;
  logic       recv_desc_ready;

  pkt_row_t   rows[$];
  logic [7:0] mem [0:65535];
  logic       bp_on;
  logic       descs_done = 1'b0;
  int         last_count = 0;
  int         cycle_count = 0;
  int         cycle_limit = 0;

  rx_dma_top rx_dma_top_i (
    .clk             (clk),
    .rst             (rst),
    .s_axis          (s_axis),
    .s_axis_valid    (s_axis_valid),
    .s_axis_ready    (s_axis_ready),
    .wr_base_addr    (wr_base_addr),
    .mem_wr          (mem_wr),
    .mem_wr_ready    (mem_wr_ready),
    .recv_desc       (recv_desc),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference data
  ////////////////////////////////////////

  // Packet byte k of packet p
  function automatic logic [7:0] payload_byte(input int p, input int k);
    return 8'(p * 53 + k * 7 + 29);
  endfunction

  // Untouched memory holds a pattern built from both address bytes
  function automatic logic [7:0] fill_byte(input addr_t a);
    return a[15:8] ^ a[7:0] ^ 8'h5a;
  endfunction

  task automatic add_row(input addr_t base, input len_t len, input dest_t dest,
                         input user_t user, input logic bp, input logic [3:0] delay);
    pkt_row_t r;
    r.base  = base;
    r.len   = len;
    r.dest  = dest;
    r.user  = user;
    r.bp    = bp;
    r.delay = delay;
    rows.push_back(r);
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_desc(input recv_desc_t exp, input recv_desc_t act);
    if (act !== exp) begin
      $write("[ERROR] recv_desc expected addr %h len %h dest %h user %h",
             exp.addr, exp.len, exp.dest, exp.user);
      $display(" actual addr %h len %h dest %h user %h",
               act.addr, act.len, act.dest, act.user);
      abort_run();
    end
  endtask

  task automatic check_byte(input addr_t a, input logic [7:0] exp);
    if (mem[a] !== exp) begin
      $display("[ERROR] mem[%h] expected %h actual %h", a, exp, mem[a]);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Memory side ready is random only for rows that ask for back-pressure
  task automatic drive_ready();
    if (bp_on) begin
      mem_wr_ready = ($urandom % 3) != 0;
    end else begin
      mem_wr_ready = 1'b1;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    drive_ready();
  endtask

  // Beats carry contiguous keep bits from lane zero and only the last one may be short
  task automatic send_packet(input int p);
    axis_beat_t beat;
    int         nbeats;
    int         n;
    logic       acc;
    bp_on  = rows[p].bp;
    nbeats = (int'(rows[p].len) + 7) / 8;
    for (int b = 0; b < nbeats; b++) begin
      n = int'(rows[p].len) - 8 * b;
      if (n > 8) begin
        n = 8;
      end
      // Unused lanes hold a marker that must never reach memory
      beat.data = {8{8'hee}};
      for (int i = 0; i < n; i++) begin
        beat.data[8*i +: 8] = payload_byte(p, 8 * b + i);
      end
      beat.keep    = strb_t'((1 << n) - 1);
      beat.last    = (b == nbeats - 1);
      beat.dest    = rows[p].dest;
      beat.user    = rows[p].user;
      s_axis       = beat;
      s_axis_valid = 1'b1;
      // Later beats carry a wrong base that the DMA must ignore
      if (b == 0) begin
        wr_base_addr = rows[p].base;
      end else begin
        wr_base_addr = ~rows[p].base;
      end
      // Inputs are stable at the falling edge so ready there decides the transfer
      do begin
        @(negedge clk);
        acc = s_axis_ready;
        next_cycle();
      end while (!acc);
    end
  endtask

  ////////////////////////////////////////
  // Memory model and timeout
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst && mem_wr.en && mem_wr_ready) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (mem_wr.strb[i]) begin
          mem[mem_wr.addr + addr_t'(i)] = mem_wr.data[8*i +: 8];
        end
      end
      if (mem_wr.last) begin
        last_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Run timed out after %0d cycles before all descriptors arrived", cycle_count);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Descriptor sink
  ////////////////////////////////////////

  // Descriptors must come in table order and each one after its own single final write
  initial begin
    recv_desc_t exp;
    recv_desc_ready = 1'b0;
    repeat (3) @(posedge clk);
    for (int d = 0; d < rows.size(); d++) begin
      do @(negedge clk); while (!recv_desc_valid);
      repeat (int'(rows[d].delay)) @(negedge clk);
      @(posedge clk);
      #1;
      recv_desc_ready = 1'b1;
      @(negedge clk);
      if (!recv_desc_valid) begin
        $display("Descriptor %0d dropped its valid before it was taken", d);
        abort_run();
      end
      exp.addr = rows[d].base;
      exp.len  = rows[d].len;
      exp.dest = rows[d].dest;
      exp.user = rows[d].user;
      check_desc(exp, recv_desc);
      if (last_count != d + 1) begin
        $display("[ERROR] mem_wr.last count expected %h actual %h", d + 1, last_count);
        abort_run();
      end
      @(posedge clk);
      #1;
      recv_desc_ready = 1'b0;
    end
    descs_done = 1'b1;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int   total_beats;
    logic done;
    rst          = 1'b1;
    s_axis       = '0;
    s_axis_valid = 1'b0;
    wr_base_addr = '0;
    mem_wr_ready = 1'b1;
    bp_on        = 1'b0;
    void'($urandom(39358));

    // Aligned bases, one with a short last beat
    add_row(16'h0100, 16'd32, 8'h11, 2'd0, 1'b0, 4'd0);
    add_row(16'h0200, 16'd24, 8'h12, 2'd1, 1'b0, 4'd0);
    add_row(16'h0300, 16'd13, 8'h13, 2'd2, 1'b0, 4'd0);
    // Unaligned bases where rows 3 and 5 spill into an extra tail write
    add_row(16'h0403, 16'd16, 8'h21, 2'd3, 1'b0, 4'd0);
    add_row(16'h0505, 16'd10, 8'h22, 2'd0, 1'b0, 4'd0);
    add_row(16'h0607, 16'd21, 8'h23, 2'd1, 1'b0, 4'd0);
    add_row(16'h0701, 16'd7,  8'h24, 2'd2, 1'b0, 4'd0);
    // Random memory back-pressure
    add_row(16'h0802, 16'd40, 8'h31, 2'd0, 1'b1, 4'd0);
    add_row(16'h0906, 16'd19, 8'h32, 2'd3, 1'b1, 4'd0);
    add_row(16'h0a00, 16'd27, 8'h33, 2'd1, 1'b1, 4'd0);
    // Slow descriptor consumer
    add_row(16'h0b04, 16'd12, 8'h41, 2'd2, 1'b0, 4'd5);
    add_row(16'h0c00, 16'd16, 8'h42, 2'd0, 1'b0, 4'd7);
    add_row(16'h0d07, 16'd9,  8'h43, 2'd3, 1'b1, 4'd3);
    // Single beat packets back to back at mixed offsets
    add_row(16'h0e00, 16'd8,  8'h51, 2'd0, 1'b0, 4'd0);
    add_row(16'h0e13, 16'd5,  8'h52, 2'd1, 1'b0, 4'd0);
    add_row(16'h0e26, 16'd4,  8'h53, 2'd2, 1'b0, 4'd0);
    add_row(16'h0e35, 16'd1,  8'h54, 2'd3, 1'b0, 4'd0);
    add_row(16'h0e47, 16'd2,  8'h55, 2'd0, 1'b1, 4'd1);

    total_beats = 0;
    foreach (rows[p]) begin
      total_beats += (int'(rows[p].len) + 7) / 8;
    end
    cycle_limit = 40 * total_beats + 200;

    for (int a = 0; a < 65536; a++) begin
      mem[addr_t'(a)] = fill_byte(addr_t'(a));
    end

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    drive_ready();

    for (int p = 0; p < rows.size(); p++) begin
      send_packet(p);
    end
    s_axis_valid = 1'b0;
    s_axis       = '0;

    do begin
      @(negedge clk);
      done = descs_done;
      next_cycle();
    end while (!done);
    bp_on = 1'b0;
    repeat (4) next_cycle();

    // Every packet byte must be in place and the bytes just outside each packet untouched
    foreach (rows[p]) begin
      for (int k = 0; k < int'(rows[p].len); k++) begin
        check_byte(addr_t'(int'(rows[p].base) + k), payload_byte(p, k));
      end
      check_byte(rows[p].base - 16'd1, fill_byte(rows[p].base - 16'd1));
      check_byte(rows[p].base + rows[p].len, fill_byte(rows[p].base + rows[p].len));
    end

    @(negedge clk);
    if (recv_desc_valid) begin
      $display("A descriptor appeared after every packet had been matched");
      abort_run();
    end else if (last_count != rows.size()) begin
      $display("[ERROR] mem_wr.last count expected %h actual %h", rows.size(), last_count);
      abort_run();
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+src
src/rx_dma_pkg.sv
src/rx_ingress.sv
src/rx_realign.sv
src/rx_desc_gen.sv
src/rx_dma_top.sv
testbench/rx_dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the receive DMA testbench with Verilator and runs it.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module rx_dma_tb \
  -Mdir obj_dir \
  -o rx_dma_sim

./obj_dir/rx_dma_sim
